// File: alu_stream.f
+incdir+include
source/alu_stream_pkg.sv
source/stream_fifo.sv
source/ingress_credit.sv
source/op_engine.sv
source/egress_credit.sv
source/alu_stream_top.sv
verification/alu_stream_tb.sv

// File: Makefile
BIN  := obj_dir/Valu_stream_tb
SRCS := $(wildcard include/*.svh source/*.sv verification/*.sv)

.PHONY: run clean

run: $(BIN)
	@$(BIN) > sim.log 2>&1; rc=$$?; cat sim.log; \
	if [ $$rc -ne 0 ] || grep -q "tests failed" sim.log; then exit 1; fi

# rebuilt only when a source or the file list changes
$(BIN): alu_stream.f $(SRCS)
	verilator --binary --timing --assert -f alu_stream.f \
		--top-module alu_stream_tb -o Valu_stream_tb

clean:
	rm -rf obj_dir sim.log

// File: verification/alu_stream_tb.sv
/*
  directed tests for alu_stream_top
  the upstream agent sends only while it holds credits
  the downstream agent never returns more credits than it has used
*/
`default_nettype none

`include "alu_stream_defines.svh"

module alu_stream_tb import alu_stream_pkg::*; ();

  localparam int NumReqs   = 62;
  localparam int Timeout   = NumReqs * 20 * 4 + 1000;
  localparam int DrainMax  = 200;
  localparam int RetHold   = 0;
  localparam int RetAuto   = 1;
  localparam int RetRandom = 2;

  typedef logic [`ALU_DATA_W-1:0] data_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic req_valid_i;
  req_t req_i;
  logic credit_o;
  logic rsp_valid_o;
  rsp_t rsp_o;
  logic rsp_credit_i = 1'b0;

  rsp_t exp_q[$];
  int   ret_mode;
  int   reqs_sent;
  int   cnt_checks;
  int   cnt_errors;
  // written by the monitor
  int   credits_back = 0;
  int   rsp_seen = 0;
  int   rsp_checks = 0;
  int   rsp_errors = 0;
  // written by the downstream agent
  int   credits_returned = 0;

  always #2 clk_i = ~clk_i;

  alu_stream_top i_alu_stream_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .credit_o     (credit_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .rsp_credit_i (rsp_credit_i)
  );

  // expected response from the opcode rules, sums wrap at the data width
  function automatic rsp_t model_rsp(req_t r);
    rsp_t m;
    int   modulus;
    int   res;
    modulus = 1 << `ALU_DATA_W;
    case (r.op)
      OP_ADD:  res = (int'(r.a) + int'(r.b)) % modulus;
      OP_SUB:  res = (int'(r.a) - int'(r.b) + modulus) % modulus;
      OP_XOR:  res = int'(r.a) ^ int'(r.b);
      default: res = int'(r.a) & int'(r.b);
    endcase
    m.tag    = r.tag;
    m.result = res[`ALU_DATA_W-1:0];
    m.zero   = (res == 0);
    return m;
  endfunction

  function automatic int up_credits();
    return `INGRESS_DEPTH + credits_back - reqs_sent;
  endfunction

  function automatic logic credit_wanted(int mode);
    logic want;
    if (mode == RetAuto) begin
      want = 1'b1;
    end else if (mode == RetRandom) begin
      want = (($urandom % 2) == 0);
    end else begin
      want = 1'b0;
    end
    return want;
  endfunction

  task automatic check_rsp(rsp_t got, rsp_t exp);
    rsp_checks++;
    if (got !== exp) begin
      rsp_errors++;
      $display("mismatch at %0t: response tag %h result %h zero %b, expected %h %h %b",
               $time, got.tag, got.result, got.zero, exp.tag, exp.result, exp.zero);
    end
  endtask

  task automatic check_credits(int got, int exp, string what);
    cnt_checks++;
    if (got != exp) begin
      cnt_errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // response and credit monitor, sampled at the edge the DUT acts on
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (credit_o) begin
        credits_back++;
      end
      if (rsp_valid_o) begin
        if (rsp_seen < exp_q.size()) begin
          check_rsp(rsp_o, exp_q[rsp_seen]);
        end else begin
          rsp_errors++;
          $display("unexpected response at %0t with no request outstanding", $time);
        end
        rsp_seen++;
      end
    end
  end

  // downstream agent returns at most one credit per cycle
  always @(negedge clk_i) begin
    if (rst_ni && (rsp_seen > credits_returned) && credit_wanted(ret_mode)) begin
      rsp_credit_i = 1'b1;
      credits_returned++;
    end else begin
      rsp_credit_i = 1'b0;
    end
  end

  // leaves req_valid_i high until the next falling edge
  task automatic send_op(op_e op, data_t a, data_t b);
    req_t r;
    r.op  = op;
    r.a   = a;
    r.b   = b;
    r.tag = reqs_sent[`ALU_TAG_W-1:0];
    @(negedge clk_i);
    while (up_credits() == 0) begin
      req_valid_i = 1'b0;
      @(negedge clk_i);
    end
    req_valid_i = 1'b1;
    req_i       = r;
    reqs_sent++;
    exp_q.push_back(model_rsp(r));
  endtask

  task automatic end_send();
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((rsp_seen < exp_q.size()) && (n < DrainMax)) begin
      @(negedge clk_i);
      n++;
    end
    if (rsp_seen < exp_q.size()) begin
      cnt_errors++;
      $display("responses missing at %0t, %0d still outstanding",
               $time, exp_q.size() - rsp_seen);
    end
  endtask

  task automatic one_op(op_e op, data_t a, data_t b);
    send_op(op, a, b);
    end_send();
    wait_drain();
  endtask

  task automatic test_reset_idle();
    repeat (10) @(negedge clk_i);
    check_credits(credits_back, 0, "credit_o pulses while idle");
    check_credits(rsp_seen, 0, "responses while idle");
  endtask

  task automatic test_each_op();
    ret_mode = RetAuto;
    one_op(OP_ADD, 16'h1234, 16'h0101);
    // wraps to zero
    one_op(OP_ADD, 16'hffff, 16'h0001);
    one_op(OP_SUB, 16'h0005, 16'h0005);
    // borrow wraps to all ones
    one_op(OP_SUB, 16'h0000, 16'h0001);
    one_op(OP_XOR, 16'ha5a5, 16'ha5a5);
    one_op(OP_XOR, 16'hf0f0, 16'h0ff0);
    one_op(OP_AND, 16'hff00, 16'h00ff);
    one_op(OP_AND, 16'hffff, 16'h1234);
  endtask

  task automatic test_burst();
    ret_mode = RetAuto;
    for (int i = 0; i < `INGRESS_DEPTH; i++) begin
      send_op(OP_ADD, data_t'(16'h1000 + i), data_t'(i * 3));
    end
    end_send();
    wait_drain();
  endtask

  task automatic test_withheld();
    int base_rsp;
    int base_crd;
    // let the downstream hand back everything it owes
    repeat (4) @(negedge clk_i);
    ret_mode = RetHold;
    base_rsp = rsp_seen;
    base_crd = credits_back;
    for (int i = 0; i < 10; i++) begin
      send_op(OP_SUB, data_t'(i * 7), data_t'(i));
    end
    end_send();
    repeat (40) @(negedge clk_i);
    check_credits(rsp_seen - base_rsp, `EGRESS_CREDITS, "responses without credit");
    // egress buffer full plus both engine stages
    check_credits(credits_back - base_crd, `EGRESS_CREDITS + `EGRESS_DEPTH + 2,
                  "requests taken under back-pressure");
    ret_mode = RetAuto;
    wait_drain();
  endtask

  task automatic test_random();
    logic [1:0] op_bits;
    int         gap;
    ret_mode = RetRandom;
    for (int i = 0; i < 40; i++) begin
      op_bits = 2'($urandom % 4);
      send_op(op_e'(op_bits), data_t'($urandom), data_t'($urandom));
      gap = int'($urandom % 3);
      if (gap != 0) begin
        end_send();
        repeat (gap - 1) @(negedge clk_i);
      end
    end
    end_send();
    wait_drain();
  endtask

  task automatic test_credit_balance();
    ret_mode = RetAuto;
    repeat (6) @(negedge clk_i);
    check_credits(credits_back, reqs_sent, "credit_o pulses against requests");
  endtask

  initial begin
    void'($urandom(27));
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    ret_mode    = RetHold;
    reqs_sent   = 0;
    cnt_checks  = 0;
    cnt_errors  = 0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_idle();
    test_each_op();
    test_burst();
    test_withheld();
    test_random();
    test_credit_balance();
    $display("%0d response checks, %0d count checks, %0d response errors, %0d count errors",
             rsp_checks, cnt_checks, rsp_errors, cnt_errors);
    if ((rsp_errors + cnt_errors) == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(Timeout);
    $display("timeout at %0t, the tests did not finish", $time);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/alu_stream_top.sv
/*
  credit-controlled command stream processor
  credit_o and rsp_credit_i each count one credit per high cycle
  responses leave in request order, three cycles after an idle entry
*/
`default_nettype none

module alu_stream_top import alu_stream_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  // upstream
  input  logic req_valid_i,
  input  req_t req_i,
  output logic credit_o,
  // downstream
  output logic rsp_valid_o,
  output rsp_t rsp_o,
  input  logic rsp_credit_i
);

  logic in_valid;
  logic in_ready;
  req_t in_req;
  logic out_valid;
  logic out_ready;
  rsp_t out_rsp;

  ingress_credit i_ingress_credit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .credit_o    (credit_o),
    .in_valid_o  (in_valid),
    .in_ready_i  (in_ready),
    .in_req_o    (in_req)
  );

  op_engine i_op_engine (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_req_i    (in_req),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_rsp_o   (out_rsp)
  );

  egress_credit i_egress_credit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .out_valid_i  (out_valid),
    .out_ready_o  (out_ready),
    .out_rsp_i    (out_rsp),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .rsp_credit_i (rsp_credit_i)
  );

endmodule

`default_nettype wire

// File: source/egress_credit.sv
/*
  output side of alu_stream
  responses go out only against downstream credits, there is no ready
  the downstream must not return more credits than it has used
*/
`default_nettype none

`include "alu_stream_defines.svh"

module egress_credit import alu_stream_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  // from the engine
  input  logic out_valid_i,
  output logic out_ready_o,
  input  rsp_t out_rsp_i,
  // downstream, credit based
  output logic rsp_valid_o,
  output rsp_t rsp_o,
  input  logic rsp_credit_i
);

  credit_cnt_t credit_cnt_q;
  logic        has_credit;
  logic        fifo_rvalid;

  assign has_credit = (credit_cnt_q != '0);

  // pass-through saves a cycle when the buffer is empty
  stream_fifo #(
    .Width ($bits(rsp_t)),
    .Depth (`EGRESS_DEPTH),
    .Pass  (1'b1)
  ) i_rsp_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (out_valid_i),
    .wready_o (out_ready_o),
    .wdata_i  (out_rsp_i),
    .rvalid_o (fifo_rvalid),
    .rready_i (has_credit),
    .rdata_o  (rsp_o)
  );

  assign rsp_valid_o = fifo_rvalid & has_credit;

  // a send and a returned credit in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_cnt_q <= credit_cnt_t'(`EGRESS_CREDITS);
    end else if (rsp_valid_o && !rsp_credit_i) begin
      credit_cnt_q <= credit_cnt_q - credit_cnt_t'(1);
    end else if (!rsp_valid_o && rsp_credit_i) begin
      credit_cnt_q <= credit_cnt_q + credit_cnt_t'(1);
    end
  end

  // catches a downstream that returns more than it consumed
  a_credit_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credit_cnt_q <= credit_cnt_t'(`EGRESS_CREDITS)
  );

endmodule

`default_nettype wire

// File: source/op_engine.sv
/*
  two-stage opcode pipeline with valid/ready on both sides
  stage one holds the request, stage two the response
  each stage moves when the next one is empty or draining
*/
`default_nettype none

`include "alu_stream_defines.svh"

module op_engine import alu_stream_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  // request side
  input  logic in_valid_i,
  output logic in_ready_o,
  input  req_t in_req_i,
  // response side
  output logic out_valid_o,
  input  logic out_ready_i,
  output rsp_t out_rsp_o
);

  logic                   s1_valid_q;
  req_t                   s1_req_q;
  logic                   s1_ready;
  logic                   s2_valid_q;
  rsp_t                   s2_rsp_q;
  logic                   s2_ready;
  logic [`ALU_DATA_W-1:0] result;
  rsp_t                   rsp_d;

  assign s2_ready = ~s2_valid_q | out_ready_i;
  assign s1_ready = ~s1_valid_q | s2_ready;

  // stage one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
    end else if (s1_ready) begin
      s1_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && s1_ready) begin
      s1_req_q <= in_req_i;
    end
  end

  // sums and differences wrap at the data width
  always_comb begin
    unique case (s1_req_q.op)
      OP_ADD:  result = s1_req_q.a + s1_req_q.b;
      OP_SUB:  result = s1_req_q.a - s1_req_q.b;
      OP_XOR:  result = s1_req_q.a ^ s1_req_q.b;
      default: result = s1_req_q.a & s1_req_q.b;
    endcase
  end

  assign rsp_d.tag    = s1_req_q.tag;
  assign rsp_d.result = result;
  assign rsp_d.zero   = (result == '0);

  // stage two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s2_valid_q <= 1'b0;
    end else if (s2_ready) begin
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_q && s2_ready) begin
      s2_rsp_q <= rsp_d;
    end
  end

  assign in_ready_o  = s1_ready;
  assign out_valid_o = s2_valid_q;
  assign out_rsp_o   = s2_rsp_q;

  // a stalled response stays put until the output side takes it
  a_stall_holds: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rsp_o)
  );

endmodule

`default_nettype wire

// File: source/ingress_credit.sv
/*
  input side of alu_stream
  the upstream may only send while it holds credits, so there is no ready
  one credit_o pulse follows every request handed to the engine
*/
`default_nettype none

`include "alu_stream_defines.svh"

module ingress_credit import alu_stream_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  // upstream, credit based
  input  logic req_valid_i,
  input  req_t req_i,
  output logic credit_o,
  // towards the engine
  output logic in_valid_o,
  input  logic in_ready_i,
  output req_t in_req_o
);

  logic fifo_wready;
  logic credit_q;

  stream_fifo #(
    .Width ($bits(req_t)),
    .Depth (`INGRESS_DEPTH),
    .Pass  (1'b0)
  ) i_req_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (req_valid_i),
    .wready_o (fifo_wready),
    .wdata_i  (req_i),
    .rvalid_o (in_valid_o),
    .rready_i (in_ready_i),
    .rdata_o  (in_req_o)
  );

  // a slot freed at this edge becomes a credit in the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= in_valid_o & in_ready_i;
    end
  end

  assign credit_o = credit_q;

  // upstream sending with no credit left would overrun the buffer
  a_no_credit_overrun: assert property (
    @(posedge clk_i) disable iff (!rst_ni) req_valid_i |-> fifo_wready
  );

endmodule

`default_nettype wire

// File: source/stream_fifo.sv
/*
  synchronous valid/ready FIFO, Depth of 1 or more
  with Pass set an empty FIFO forwards wdata_i to the read side
  in the same cycle, so rvalid_o then depends on wvalid_i
*/
`default_nettype none

module stream_fifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 4,
  parameter bit          Pass  = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // write side
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  // read side
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int unsigned AddrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned PtrW  = AddrW + 1;

  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  logic [AddrW-1:0] waddr;
  logic [AddrW-1:0] raddr;
  logic             push;
  logic             pop;
  logic             full;
  logic             fifo_empty;
  logic [PtrW-1:0]  occupancy;
  logic [Width-1:0] storage_q [Depth];

  // advance within 0..Depth-1 and flip the wrap bit at the end
  function automatic logic [PtrW-1:0] ptr_next(logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] nxt;
    if (ptr[AddrW-1:0] == AddrW'(Depth - 1)) begin
      nxt = {~ptr[AddrW], {AddrW{1'b0}}};
    end else begin
      nxt = ptr + PtrW'(1);
    end
    return nxt;
  endfunction

  assign waddr = wptr_q[AddrW-1:0];
  assign raddr = rptr_q[AddrW-1:0];

  // same slot, different lap means full
  assign full       = (waddr == raddr) && (wptr_q[AddrW] != rptr_q[AddrW]);
  assign fifo_empty = (wptr_q == rptr_q);

  assign wready_o = ~full;
  assign push     = wvalid_i & ~full;
  assign pop      = rvalid_o & rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_next(wptr_q);
      end
      if (pop) begin
        rptr_q <= ptr_next(rptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      storage_q[waddr] <= wdata_i;
    end
  end

  if (Pass) begin : gen_pass
    // a push into an empty FIFO is popped at the same edge
    assign rvalid_o = ~fifo_empty | wvalid_i;
    assign rdata_o  = fifo_empty ? wdata_i : storage_q[raddr];
  end else begin : gen_no_pass
    assign rvalid_o = ~fifo_empty;
    assign rdata_o  = storage_q[raddr];
  end

  // entry count, only for checking
  always_comb begin
    if (wptr_q[AddrW] == rptr_q[AddrW]) begin
      occupancy = PtrW'(waddr) - PtrW'(raddr);
    end else begin
      occupancy = PtrW'(Depth) - PtrW'(raddr) + PtrW'(waddr);
    end
  end

  a_occupancy_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) occupancy <= PtrW'(Depth)
  );

endmodule

`default_nettype wire

// File: source/alu_stream_pkg.sv
/*
  types shared by the alu_stream blocks and the testbench
  every 2-bit opcode value is defined, so no error response exists
*/
`default_nettype none

`include "alu_stream_defines.svh"

package alu_stream_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_AND = 2'd3
  } op_e;

  // 38 bits in total
  typedef struct packed {
    op_e                   op;
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;
    logic [`ALU_TAG_W-1:0]  tag;
  } req_t;

  // 21 bits in total
  typedef struct packed {
    logic [`ALU_TAG_W-1:0]  tag;
    logic [`ALU_DATA_W-1:0] result;
    logic                   zero;
  } rsp_t;

  // holds 0 up to EGRESS_CREDITS
  typedef logic [$clog2(`EGRESS_CREDITS + 1)-1:0] credit_cnt_t;

endpackage

`default_nettype wire

// File: include/alu_stream_defines.svh
/*
  widths, buffer depths and credit counts for alu_stream
  INGRESS_DEPTH is also the upstream's credit count after reset
  EGRESS_CREDITS must be at least 1 or no response ever leaves
*/
`ifndef ALU_STREAM_DEFINES_SVH
`define ALU_STREAM_DEFINES_SVH

// operand, result and tag widths
`define ALU_DATA_W 16
`define ALU_TAG_W 4

// buffer depths
`define INGRESS_DEPTH 4
`define EGRESS_DEPTH 4

// downstream grant after reset
`define EGRESS_CREDITS 2

`endif
